// ==== verification/raster_patterns.txt ====
// triangle count; per triangle v0x v0y v1x v1y v2x v2y, then the pixel count,
// then one line per pixel: x y l0 l1 l2 (Q16.16 words in hex)
00000005
00000000 00000000 00000000 00010000 00010000 00000000
00000004
00000000 00000000 00010000 00000000 00000000
00000001 00000000 00000000 00000000 00010000
00000000 00000001 00000000 00010000 00000000
00000001 00000001 ffff0000 00010000 00010000
00000000 00000000 00010000 00000000 00000000 00010000
00000000
00000000 00000000 00010000 00010000 00020000 00020000
00000000
013e0000 00ee0000 013e0000 00f20000 01420000 00ee0000
00000004
0000013e 000000ee 00010000 00000000 00000000
0000013f 000000ee 0000c000 00000000 00004000
0000013e 000000ef 0000c000 00004000 00000000
0000013f 000000ef 00008000 00004000 00004000
00000000 00000000 00000000 00018000 00018000 00000000
00000004
00000000 00000000 0000ffff 00000000 00000001
00000001 00000000 00005555 00000000 0000aaab
00000000 00000001 00005555 0000aaaa 00000001
00000001 00000001 ffffaaaa 0000aaaa 0000aaac

// ==== raster_core.f ====
logic/raster_pkg.sv
logic/fix_recip.sv
logic/pixel_scanner.sv
logic/bary_pipe.sv
logic/raster_core.sv
verification/clock_gen.sv
verification/raster_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the raster core testbench.

VERILATOR ?= verilator
TOP       ?= raster_core_tb
FILELIST  ?= raster_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/raster_core_tb.sv ====
`timescale 1ns/1ps

module raster_core_tb;

    localparam int pat_depth = 256;
    localparam int one_q     = 1 << raster_pkg::decimal_pos;  // 1.0 in Q16.16.

    logic                                     clk;
    logic                                     nrst;
    logic                                     run;
    logic signed [raster_pkg::word_width-1:0] v0x, v0y, v1x, v1y, v2x, v2y;
    logic                                     pix_valid, pix_ready, pix_last;
    logic [raster_pkg::sc_width-1:0]          pix_x, pix_y;
    logic signed [raster_pkg::word_width-1:0] pix_l0, pix_l1, pix_l2;
    logic                                     busy;

    logic [31:0] pat [0:pat_depth-1];
    integer      seed;
    int          cycle_count;
    int          cycle_limit;
    int          err_count;
    int          check_count;
    int          fail_tests;

    // offer that was not taken last cycle.
    logic        held;
    logic        held_last;
    logic [31:0] held_x, held_y, held_l0, held_l1, held_l2;

    clock_gen clk_gen_i (
        .clk_o  (clk),
        .nrst_o (nrst)
    );

    raster_core dut_i (
        .clk_i       (clk),
        .nrst_i      (nrst),
        .run_i       (run),
        .v0x_i       (v0x),
        .v0y_i       (v0y),
        .v1x_i       (v1x),
        .v1y_i       (v1y),
        .v2x_i       (v2x),
        .v2y_i       (v2y),
        .pix_valid_o (pix_valid),
        .pix_ready_i (pix_ready),
        .pix_last_o  (pix_last),
        .pix_x_o     (pix_x),
        .pix_y_o     (pix_y),
        .pix_l0_o    (pix_l0),
        .pix_l1_o    (pix_l1),
        .pix_l2_o    (pix_l2),
        .busy_o      (busy)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("** Error %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // one clock, then new back-pressure 1 ns after the edge.
    task automatic next_cycle();
        integer r;
        @(posedge clk);
        #1;
        r = $random(seed);
        pix_ready = r[0];
    endtask

    // bounds the whole run in clock cycles.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic string test_name(input int t);
        case (t)
            0: return "right triangle";
            1: return "positive area cull";
            2: return "zero area cull";
            3: return "clamped to screen";
            4: return "back to back, fractional";
            default: return "triangle";
        endcase
    endfunction

    // samples mid cycle what the next rising edge will see.
    task automatic watch_output(input int rec_base, input int n_rec, inout int got);
        int p;
        @(negedge clk);
        if (held) begin
            check_value("pix_valid_o held", 1, 32'(pix_valid));
            check_value("pix_last_o held", 32'(held_last), 32'(pix_last));
            check_value("pix_x_o held", held_x, 32'(pix_x));
            check_value("pix_y_o held", held_y, 32'(pix_y));
            check_value("pix_l0_o held", held_l0, pix_l0);
            check_value("pix_l1_o held", held_l1, pix_l1);
            check_value("pix_l2_o held", held_l2, pix_l2);
        end
        held      = pix_valid && !pix_ready;
        held_last = pix_last;
        held_x    = 32'(pix_x);
        held_y    = 32'(pix_y);
        held_l0   = pix_l0;
        held_l1   = pix_l1;
        held_l2   = pix_l2;
        if (pix_valid && pix_ready) begin
            if (got >= n_rec) begin
                err_count++;
                $display("unexpected output record at %0t, only %0d expected", $time, n_rec);
            end else begin
                p = rec_base + 5 * got;
                check_value("pix_x_o", pat[p], 32'(pix_x));
                check_value("pix_y_o", pat[p + 1], 32'(pix_y));
                check_value("pix_l0_o", pat[p + 2], pix_l0);
                check_value("pix_l1_o", pat[p + 3], pix_l1);
                check_value("pix_l2_o", pat[p + 4], pix_l2);
                check_value("pix_last_o", 32'(got == n_rec - 1), 32'(pix_last));
                check_value("l0+l1+l2", one_q, 32'(pix_l0 + pix_l1 + pix_l2));
            end
            got++;
        end
    endtask

    task automatic run_triangle(input int t, inout int ptr);
        int n_rec;
        int got;
        int errs_before;
        int n;
        v0x = pat[ptr];
        v0y = pat[ptr + 1];
        v1x = pat[ptr + 2];
        v1y = pat[ptr + 3];
        v2x = pat[ptr + 4];
        v2y = pat[ptr + 5];
        n_rec = pat[ptr + 6];
        ptr = ptr + 7;
        got = 0;
        n = 0;
        errs_before = err_count;
        run = 1'b1;
        next_cycle();
        run = 1'b0;
        check_value("busy_o", 1, 32'(busy));
        while (busy) begin
            watch_output(ptr, n_rec, got);
            next_cycle();
            n++;
            run = (n == 3);  // a start while busy must be ignored.
        end
        run = 1'b0;
        check_value("record count", n_rec, got);
        ptr = ptr + 5 * n_rec;
        if (err_count != errs_before) fail_tests++;
        $display("test %0d %s: %0d of %0d records, %0s", t, test_name(t), got, n_rec,
                 (err_count == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int ptr;
        int n_tri;
        int pixels;
        run         = 1'b0;
        v0x         = '0;
        v0y         = '0;
        v1x         = '0;
        v1y         = '0;
        v2x         = '0;
        v2y         = '0;
        pix_ready   = 1'b0;
        seed        = 3;
        cycle_count = 0;
        err_count   = 0;
        check_count = 0;
        fail_tests  = 0;
        held        = 1'b0;
        $readmemh("verification/raster_patterns.txt", pat);
        n_tri  = pat[0];
        ptr    = 1;
        pixels = 0;
        for (int t = 0; t < n_tri; t++) begin
            pixels += pat[ptr + 6];
            ptr += 7 + 5 * pat[ptr + 6];
        end
        cycle_limit = 60 * pixels + 200 * n_tri;
        if (n_tri == 0) begin
            err_count++;
            $display("no triangles were read from the pattern file");
        end
        while (nrst !== 1'b1) next_cycle();
        check_value("pix_valid_o after reset", 0, 32'(pix_valid));
        check_value("busy_o after reset", 0, 32'(busy));
        ptr = 1;
        for (int t = 0; t < n_tri; t++) run_triangle(t, ptr);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tri, fail_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk_o,
    output logic nrst_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;  // 8 ns period.
    end

    // reset held for 10 rising edges, released mid cycle.
    initial begin
        nrst_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        nrst_o = 1'b1;
    end

endmodule

// ==== logic/raster_core.sv ====
`timescale 1ns/1ps

module raster_core (
    input  logic                                    clk_i,
    input  logic                                    nrst_i,
    input  logic                                    run_i,
    input  logic signed [raster_pkg::word_width-1:0] v0x_i,
    input  logic signed [raster_pkg::word_width-1:0] v0y_i,
    input  logic signed [raster_pkg::word_width-1:0] v1x_i,
    input  logic signed [raster_pkg::word_width-1:0] v1y_i,
    input  logic signed [raster_pkg::word_width-1:0] v2x_i,
    input  logic signed [raster_pkg::word_width-1:0] v2y_i,
    output logic                                    pix_valid_o,
    input  logic                                    pix_ready_i,
    output logic                                    pix_last_o,
    output logic [raster_pkg::sc_width-1:0]          pix_x_o,
    output logic [raster_pkg::sc_width-1:0]          pix_y_o,
    output logic signed [raster_pkg::word_width-1:0] pix_l0_o,
    output logic signed [raster_pkg::word_width-1:0] pix_l1_o,
    output logic signed [raster_pkg::word_width-1:0] pix_l2_o,
    output logic                                    busy_o
);

    logic                                    scan_start;
    logic                                    pos_valid, pos_ready, pos_last;
    logic [raster_pkg::sc_width-1:0]          pos_x, pos_y;
    logic                                    recip_start, recip_done;
    logic signed [raster_pkg::word_width-1:0] recip_a, recip_y;

    pixel_scanner scanner_i (
        .clk_i       (clk_i),
        .nrst_i      (nrst_i),
        .start_i     (scan_start),
        .v0x_i       (v0x_i),
        .v0y_i       (v0y_i),
        .v1x_i       (v1x_i),
        .v1y_i       (v1y_i),
        .v2x_i       (v2x_i),
        .v2y_i       (v2y_i),
        .pos_valid_o (pos_valid),
        .pos_ready_i (pos_ready),
        .pos_last_o  (pos_last),
        .pos_x_o     (pos_x),
        .pos_y_o     (pos_y)
    );

    bary_pipe bary_i (
        .clk_i         (clk_i),
        .nrst_i        (nrst_i),
        .run_i         (run_i),
        .v0x_i         (v0x_i),
        .v0y_i         (v0y_i),
        .v1x_i         (v1x_i),
        .v1y_i         (v1y_i),
        .v2x_i         (v2x_i),
        .v2y_i         (v2y_i),
        .scan_start_o  (scan_start),
        .pos_valid_i   (pos_valid),
        .pos_ready_o   (pos_ready),
        .pos_last_i    (pos_last),
        .pos_x_i       (pos_x),
        .pos_y_i       (pos_y),
        .recip_start_o (recip_start),
        .recip_a_o     (recip_a),
        .recip_done_i  (recip_done),
        .recip_y_i     (recip_y),
        .pix_valid_o   (pix_valid_o),
        .pix_ready_i   (pix_ready_i),
        .pix_last_o    (pix_last_o),
        .pix_x_o       (pix_x_o),
        .pix_y_o       (pix_y_o),
        .pix_l0_o      (pix_l0_o),
        .pix_l1_o      (pix_l1_o),
        .pix_l2_o      (pix_l2_o),
        .busy_o        (busy_o)
    );

    fix_recip recip_i (
        .clk_i   (clk_i),
        .nrst_i  (nrst_i),
        .start_i (recip_start),
        .a_i     (recip_a),
        .done_o  (recip_done),
        .y_o     (recip_y)
    );

endmodule

// ==== logic/bary_pipe.sv ====
`timescale 1ns/1ps

module bary_pipe (
    input  logic                                    clk_i,
    input  logic                                    nrst_i,
    input  logic                                    run_i,
    input  logic signed [raster_pkg::word_width-1:0] v0x_i,
    input  logic signed [raster_pkg::word_width-1:0] v0y_i,
    input  logic signed [raster_pkg::word_width-1:0] v1x_i,
    input  logic signed [raster_pkg::word_width-1:0] v1y_i,
    input  logic signed [raster_pkg::word_width-1:0] v2x_i,
    input  logic signed [raster_pkg::word_width-1:0] v2y_i,
    output logic                                    scan_start_o,
    input  logic                                    pos_valid_i,
    output logic                                    pos_ready_o,
    input  logic                                    pos_last_i,
    input  logic [raster_pkg::sc_width-1:0]          pos_x_i,
    input  logic [raster_pkg::sc_width-1:0]          pos_y_i,
    output logic                                    recip_start_o,
    output logic signed [raster_pkg::word_width-1:0] recip_a_o,
    input  logic                                    recip_done_i,
    input  logic signed [raster_pkg::word_width-1:0] recip_y_i,
    output logic                                    pix_valid_o,
    input  logic                                    pix_ready_i,
    output logic                                    pix_last_o,
    output logic [raster_pkg::sc_width-1:0]          pix_x_o,
    output logic [raster_pkg::sc_width-1:0]          pix_y_o,
    output logic signed [raster_pkg::word_width-1:0] pix_l0_o,
    output logic signed [raster_pkg::word_width-1:0] pix_l1_o,
    output logic signed [raster_pkg::word_width-1:0] pix_l2_o,
    output logic                                    busy_o
);

    raster_pkg::bary_state_t state;

    // shared operators.
    logic signed [raster_pkg::word_width-1:0]   s1a, s1b, s1y;
    logic signed [raster_pkg::word_width-1:0]   a1a, a1b, a1y;
    logic signed [raster_pkg::word_width-1:0]   m1a, m1b, m1y;
    logic signed [2*raster_pkg::word_width-1:0] m1_full;

    // edge terms.
    logic signed [raster_pkg::word_width-1:0] y1my2, x2mx1, x0mx2, y2my0;

    logic signed [raster_pkg::word_width-1:0] dx, dy;
    logic signed [raster_pkg::word_width-1:0] prod;  // partial product.
    logic [raster_pkg::word_width-1:0]        px_q, py_q;

    assign s1y     = s1a - s1b;
    assign a1y     = a1a + a1b;
    assign m1_full = m1a * m1b;
    assign m1y     = m1_full[raster_pkg::decimal_pos +: raster_pkg::word_width];

    assign px_q = {{(raster_pkg::word_width - raster_pkg::sc_width - raster_pkg::decimal_pos){1'b0}},
                   pos_x_i, {raster_pkg::decimal_pos{1'b0}}};
    assign py_q = {{(raster_pkg::word_width - raster_pkg::sc_width - raster_pkg::decimal_pos){1'b0}},
                   pos_y_i, {raster_pkg::decimal_pos{1'b0}}};

    assign pos_ready_o = (state == raster_pkg::s_await_pos);
    assign busy_o      = (state != raster_pkg::s_ready);

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state         <= raster_pkg::s_ready;
            scan_start_o  <= 1'b0;
            recip_start_o <= 1'b0;
            pix_valid_o   <= 1'b0;
            pix_l0_o      <= raster_pkg::word_smax;
            pix_l1_o      <= raster_pkg::word_smax;
            pix_l2_o      <= raster_pkg::word_smax;
        end else begin
            case (state)
                raster_pkg::s_ready: begin
                    if (run_i) state <= raster_pkg::s_setup1;
                end
                raster_pkg::s_setup7: begin
                    recip_start_o <= 1'b1;
                    state         <= raster_pkg::s_wait_recip;
                end
                raster_pkg::s_wait_recip: begin
                    recip_start_o <= 1'b0;
                    if (recip_done_i) state <= raster_pkg::s_check_area;
                end
                raster_pkg::s_check_area: begin
                    if (recip_a_o < 0) begin  // negative area is front facing.
                        scan_start_o <= 1'b1;
                        state        <= raster_pkg::s_await_pos;
                    end else begin
                        state <= raster_pkg::s_ready;
                    end
                end
                raster_pkg::s_await_pos: begin
                    scan_start_o <= 1'b0;
                    if (pos_valid_i) state <= raster_pkg::s_run1;
                end
                raster_pkg::s_run5: begin
                    pix_l0_o <= m1y;
                    state    <= raster_pkg::s_run6;
                end
                raster_pkg::s_run8: begin
                    pix_l1_o <= m1y;
                    state    <= raster_pkg::s_run9;
                end
                raster_pkg::s_run9: begin
                    pix_l2_o    <= s1y;
                    pix_valid_o <= 1'b1;
                    state       <= raster_pkg::s_complete;
                end
                raster_pkg::s_complete: begin
                    if (pix_ready_i) begin
                        pix_valid_o <= 1'b0;
                        state <= pix_last_o ? raster_pkg::s_ready : raster_pkg::s_await_pos;
                    end
                end
                default: state <= raster_pkg::bary_state_t'(state + 5'd1);
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state)
            raster_pkg::s_ready: begin
                s1a <= v1y_i;
                s1b <= v2y_i;
            end
            raster_pkg::s_setup1: begin
                y1my2 <= s1y;
                s1a   <= v0x_i;
                s1b   <= v2x_i;
            end
            raster_pkg::s_setup2: begin
                x0mx2 <= s1y;
                m1a   <= y1my2;
                m1b   <= s1y;
                s1a   <= v2x_i;
                s1b   <= v1x_i;
            end
            raster_pkg::s_setup3: begin
                x2mx1 <= s1y;
                prod  <= m1y;
                s1a   <= v0y_i;
                s1b   <= v2y_i;
            end
            raster_pkg::s_setup4: begin
                m1a <= x2mx1;
                m1b <= s1y;  // y0 - y2.
                s1a <= v2y_i;
                s1b <= v0y_i;
            end
            raster_pkg::s_setup5: begin
                y2my0 <= s1y;
                a1a   <= prod;
                a1b   <= m1y;
            end
            raster_pkg::s_setup6: recip_a_o <= a1y;  // doubled area.
            raster_pkg::s_await_pos: begin
                if (pos_valid_i) begin
                    pix_x_o    <= pos_x_i;
                    pix_y_o    <= pos_y_i;
                    pix_last_o <= pos_last_i;
                    s1a        <= px_q;
                    s1b        <= v2x_i;
                    dy         <= py_q;
                end
            end
            raster_pkg::s_run1: begin
                dx  <= s1y;
                m1a <= y1my2;
                m1b <= s1y;
                s1a <= dy;
                s1b <= v2y_i;
            end
            raster_pkg::s_run2: begin
                dy   <= s1y;
                prod <= m1y;
                m1a  <= x2mx1;
                m1b  <= s1y;
            end
            raster_pkg::s_run3: begin
                a1a <= prod;
                a1b <= m1y;
                m1a <= y2my0;
                m1b <= dx;
            end
            raster_pkg::s_run4: begin
                prod <= m1y;
                m1a  <= a1y;
                m1b  <= recip_y_i;
            end
            raster_pkg::s_run5: begin
                m1a <= x0mx2;
                m1b <= dy;
                s1a <= 1 << raster_pkg::decimal_pos;
                s1b <= m1y;  // 1.0 - l0.
            end
            raster_pkg::s_run6: begin
                a1a <= prod;
                a1b <= m1y;
            end
            raster_pkg::s_run7: begin
                m1a <= a1y;
                m1b <= recip_y_i;
            end
            raster_pkg::s_run8: begin
                s1a <= s1y;
                s1b <= m1y;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/pixel_scanner.sv ====
`timescale 1ns/1ps

module pixel_scanner (
    input  logic                                    clk_i,
    input  logic                                    nrst_i,
    input  logic                                    start_i,
    input  logic signed [raster_pkg::word_width-1:0] v0x_i,
    input  logic signed [raster_pkg::word_width-1:0] v0y_i,
    input  logic signed [raster_pkg::word_width-1:0] v1x_i,
    input  logic signed [raster_pkg::word_width-1:0] v1y_i,
    input  logic signed [raster_pkg::word_width-1:0] v2x_i,
    input  logic signed [raster_pkg::word_width-1:0] v2y_i,
    output logic                                    pos_valid_o,
    input  logic                                    pos_ready_i,
    output logic                                    pos_last_o,
    output logic [raster_pkg::sc_width-1:0]          pos_x_o,
    output logic [raster_pkg::sc_width-1:0]          pos_y_o
);

    raster_pkg::scan_state_t          state;
    logic [raster_pkg::sc_width-1:0] box_x0, box_x1, box_y0, box_y1;
    logic [raster_pkg::sc_width-1:0] min_x, max_x, max_y;

    function automatic logic signed [raster_pkg::word_width-1:0] min3(
        input logic signed [raster_pkg::word_width-1:0] a,
        input logic signed [raster_pkg::word_width-1:0] b,
        input logic signed [raster_pkg::word_width-1:0] c
    );
        logic signed [raster_pkg::word_width-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [raster_pkg::word_width-1:0] max3(
        input logic signed [raster_pkg::word_width-1:0] a,
        input logic signed [raster_pkg::word_width-1:0] b,
        input logic signed [raster_pkg::word_width-1:0] c
    );
        logic signed [raster_pkg::word_width-1:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // whole pixel of a Q16.16 value, kept on screen.
    function automatic logic [raster_pkg::sc_width-1:0] clamp(
        input logic signed [raster_pkg::word_width-1:0] v,
        input int                                      limit
    );
        logic signed [raster_pkg::word_width-1:0] iv;
        iv = v >>> raster_pkg::decimal_pos;
        if (iv < 0) return '0;
        if (iv > limit) return limit[raster_pkg::sc_width-1:0];
        return iv[raster_pkg::sc_width-1:0];
    endfunction

    assign box_x0 = clamp(min3(v0x_i, v1x_i, v2x_i), raster_pkg::screen_width - 1);
    assign box_x1 = clamp(max3(v0x_i, v1x_i, v2x_i), raster_pkg::screen_width - 1);
    assign box_y0 = clamp(min3(v0y_i, v1y_i, v2y_i), raster_pkg::screen_height - 1);
    assign box_y1 = clamp(max3(v0y_i, v1y_i, v2y_i), raster_pkg::screen_height - 1);

    assign pos_valid_o = (state == raster_pkg::s_emit);
    assign pos_last_o  = (pos_x_o == max_x) && (pos_y_o == max_y);

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state   <= raster_pkg::s_idle;
            pos_x_o <= '0;
            pos_y_o <= '0;
        end else begin
            case (state)
                raster_pkg::s_idle: begin
                    if (start_i) begin
                        state   <= raster_pkg::s_emit;
                        pos_x_o <= box_x0;
                        pos_y_o <= box_y0;
                    end
                end
                raster_pkg::s_emit: begin
                    if (pos_ready_i) begin
                        if (pos_last_o) begin
                            state <= raster_pkg::s_idle;
                        end else if (pos_x_o == max_x) begin  // next row.
                            pos_x_o <= min_x;
                            pos_y_o <= pos_y_o + 1'b1;
                        end else begin
                            pos_x_o <= pos_x_o + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == raster_pkg::s_idle && start_i) begin
            min_x <= box_x0;
            max_x <= box_x1;
            max_y <= box_y1;
        end
    end

endmodule

// ==== logic/fix_recip.sv ====
`timescale 1ns/1ps

module fix_recip (
    input  logic                                    clk_i,
    input  logic                                    nrst_i,
    input  logic                                    start_i,
    input  logic signed [raster_pkg::word_width-1:0] a_i,
    output logic                                    done_o,
    output logic signed [raster_pkg::word_width-1:0] y_o
);

    logic                                     active;
    logic [$clog2(raster_pkg::recip_iter)-1:0] cnt;
    logic                                     neg;
    logic                                     zero;
    logic [raster_pkg::word_width-1:0]         div;
    logic [raster_pkg::word_width-1:0]         rem;
    logic [raster_pkg::word_width-1:0]         quo;
    logic [raster_pkg::word_width:0]           rem_sh;
    logic [raster_pkg::word_width:0]           rem_sub;
    logic [raster_pkg::word_width-1:0]         rem_nxt;
    logic [raster_pkg::word_width-1:0]         quo_nxt;

    // one restoring step.
    always_comb begin
        rem_sh  = {rem, 1'b0};
        rem_sub = rem_sh - {1'b0, div};
        if (rem_sh >= {1'b0, div}) begin
            rem_nxt = rem_sub[raster_pkg::word_width-1:0];
            quo_nxt = {quo[raster_pkg::word_width-2:0], 1'b1};
        end else begin
            rem_nxt = rem_sh[raster_pkg::word_width-1:0];
            quo_nxt = {quo[raster_pkg::word_width-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            active <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i && !active) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (active) begin
                cnt <= cnt + 1'b1;
                if (cnt == raster_pkg::recip_iter - 1) begin
                    active <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i && !active) begin
            rem  <= 1;  // bit 32 of the dividend 2^32.
            quo  <= '0;
            div  <= a_i[raster_pkg::word_width-1] ? -a_i : a_i;
            neg  <= a_i[raster_pkg::word_width-1];
            zero <= (a_i == 0);
        end else if (active) begin
            rem <= rem_nxt;
            quo <= quo_nxt;
            if (cnt == raster_pkg::recip_iter - 1) begin
                if (zero) y_o <= {1'b0, {(raster_pkg::word_width - 1){1'b1}}};
                else      y_o <= neg ? -quo_nxt : quo_nxt;
            end
        end
    end

endmodule

// ==== logic/raster_pkg.sv ====
package raster_pkg;

    // Q16.16 fixed point.
    localparam int word_width  = 32;
    localparam int decimal_pos = 16;

    localparam int screen_width  = 320;
    localparam int screen_height = 240;
    localparam int sc_width      = 9;  // wide enough for 0..319.

    localparam logic signed [word_width-1:0] word_smax = 1 << (word_width - 2);

    localparam int recip_iter = 32;  // one quotient bit per step.

    typedef enum logic [4:0] {
        s_ready,
        s_setup1, s_setup2, s_setup3, s_setup4, s_setup5, s_setup6, s_setup7,
        s_wait_recip,
        s_check_area,
        s_await_pos,
        s_run1, s_run2, s_run3, s_run4, s_run5, s_run6, s_run7, s_run8, s_run9,
        s_complete
    } bary_state_t;

    typedef enum logic {
        s_idle,
        s_emit
    } scan_state_t;

endpackage
